/* verilog/unpack_pkg.sv */
`default_nettype none

package unpack_pkg;

    // width of the word count field in a command
    localparam int WLEN_MAX = 12;

    // one unpack request from the register block
    typedef struct packed {
        // byte offset of the first word inside the first packed word
        logic [1:0]          offset;
        // bytes per word minus one
        logic [1:0]          bpw;
        // number of words to produce
        logic [WLEN_MAX-1:0] words;
    } unpack_cmd_t;

    // packed little-endian input word
    typedef struct packed {
        logic [31:0] data;
    } pack_word_t;

    // unpacked output beat, bytes at the low end
    typedef struct packed {
        logic        last;
        logic [31:0] data;
    } unpack_beat_t;

endpackage

`default_nettype wire

/* verilog/apb_pkg.sv */
`default_nettype none

package apb_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register map
    localparam logic [3:0] REG_CMD    = 4'h0;
    localparam logic [3:0] REG_CTRL   = 4'h4;
    localparam logic [3:0] REG_STATUS = 4'h8;

endpackage

`default_nettype wire

/* verilog/stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type T          = logic [31:0],
    parameter int  FIFO_DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    T                 mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] next_count;
    logic             push;
    logic             pop;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_comb begin
        next_count = count;
        if (push && !pop) begin
            next_count = count + 1'b1;
        end else if (pop && !push) begin
            next_count = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_ready  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count     <= next_count;
            // flags follow the new fill level
            in_ready  <= (next_count != CNT_W'(FIFO_DEPTH));
            out_valid <= (next_count != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    assign out_data = mem[rd_ptr];

endmodule

`default_nettype wire

/* verilog/data_unpacker.sv */
`timescale 1ns/1ps
`default_nettype none

module data_unpacker #(
    parameter int WORDS_ZERO = 0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  unpack_pkg::unpack_cmd_t  cmd,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    output logic                     cmd_done,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  unpack_pkg::pack_word_t   in_word,
    output logic                     out_valid,
    input  logic                     out_ready,
    output unpack_pkg::unpack_beat_t out_beat
);
    import unpack_pkg::*;

    logic                cmd_xfer;
    logic                in_xfer;
    logic                set_out_valid;
    logic                set_in_ready;

    // active command state
    logic                c_valid;
    logic                c_init;
    logic                c_last;
    logic [WLEN_MAX-1:0] c_words;
    logic [1:0]          c_bpw;
    logic [3:0]          c_mask;
    logic                c_finish;

    // leftover bytes of the previous input word
    logic [1:0]          buf_cnt;
    logic [1:0]          next_buf_cnt;
    logic [23:0]         buf_data;
    logic [31:0]         joined;
    logic [31:0]         byte_mask;

    logic                in_ready_pre;

    assign cmd_ready = !c_valid;
    assign cmd_xfer  = cmd_valid && cmd_ready;
    assign in_xfer   = in_valid && in_ready;
    assign c_finish  = c_last && set_out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            c_valid  <= 1'b0;
            cmd_done <= 1'b0;
        end else begin
            c_valid  <= (c_valid && !c_finish) || cmd_xfer;
            cmd_done <= c_valid && c_finish;
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            c_init <= 1'b0;
        end
        if (set_out_valid && !c_last) begin
            c_last  <= (WORDS_ZERO != 0) ? (c_words == WLEN_MAX'(1)) :
                                           (c_words == WLEN_MAX'(2));
            c_words <= c_words - 1'b1;
        end
        if (cmd_xfer) begin
            // nonzero offset needs one word fetched before any output
            c_init  <= (cmd.offset != 2'd0);
            c_last  <= (WORDS_ZERO != 0) ? (cmd.words == '0) :
                                           (cmd.words == WLEN_MAX'(1));
            c_words <= cmd.words;
            c_bpw   <= cmd.bpw;
            case (cmd.bpw)
                2'd0:    c_mask <= 4'b0001;
                2'd1:    c_mask <= 4'b0011;
                2'd2:    c_mask <= 4'b0111;
                default: c_mask <= 4'b1111;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_cnt <= 2'd0;
        end else begin
            buf_cnt <= next_buf_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer) begin
            buf_data <= in_word.data[31:8];
        end
    end

    always_comb begin
        next_buf_cnt = buf_cnt;
        set_in_ready = 1'b0;
        if (c_valid) begin
            if (set_out_valid) begin
                next_buf_cnt = buf_cnt - c_bpw - 2'd1;
            end
            // fetch ahead when the next beat would run the buffer dry
            if (!c_last || c_init) begin
                set_in_ready = (next_buf_cnt <= c_bpw);
            end
        end
        if (cmd_xfer) begin
            // bytes left in the first word after skipping the offset
            next_buf_cnt = 2'd0 - cmd.offset;
            set_in_ready = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready_pre <= 1'b0;
        end else if (set_in_ready) begin
            in_ready_pre <= 1'b1;
        end else if (in_xfer) begin
            in_ready_pre <= 1'b0;
        end
    end

    // no fetch while the output register is stalled
    assign in_ready = in_ready_pre && (out_ready || !out_valid);

    assign set_out_valid = c_valid && !c_init && (out_ready || !out_valid) &&
                           (!in_ready_pre || in_valid);

    always_comb begin
        case (buf_cnt)
            2'd0:    joined = in_word.data;
            2'd1:    joined = {in_word.data[23:0], buf_data[23:16]};
            2'd2:    joined = {in_word.data[15:0], buf_data[23:8]};
            default: joined = {in_word.data[7:0], buf_data};
        endcase
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            byte_mask[8*i +: 8] = {8{c_mask[i]}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= (out_valid && !out_ready) || set_out_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (set_out_valid) begin
            out_beat.data <= joined & byte_mask;
            out_beat.last <= c_last;
        end
    end

endmodule

`default_nettype wire

/* verilog/unpack_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module unpack_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  apb_pkg::apb_req_t       apb_req,
    output apb_pkg::apb_rsp_t       apb_rsp,
    output unpack_pkg::unpack_cmd_t cmd,
    output logic                    cmd_valid,
    input  logic                    cmd_ready,
    input  logic                    cmd_done
);
    import apb_pkg::*;
    import unpack_pkg::*;

    logic        access;
    logic        wr_access;
    logic        addr_ok;
    logic        go_wr;
    logic        go_err;
    logic        busy;
    logic [15:0] done_cnt;
    logic [31:0] rdata;

    // second cycle of a transfer
    assign access    = apb_req.psel && apb_req.penable;
    assign wr_access = access && apb_req.pwrite;

    assign addr_ok = (apb_req.paddr == REG_CMD) || (apb_req.paddr == REG_CTRL) ||
                     (apb_req.paddr == REG_STATUS);
    assign go_wr   = wr_access && (apb_req.paddr == REG_CTRL) && apb_req.pwdata[0];
    assign go_err  = go_wr && busy;

    always_comb begin
        rdata = '0;
        case (apb_req.paddr)
            REG_CMD: begin
                rdata[1:0]              = cmd.offset;
                rdata[3:2]              = cmd.bpw;
                rdata[16 +: WLEN_MAX]   = cmd.words;
            end
            REG_STATUS: begin
                rdata[0]     = busy;
                rdata[31:16] = done_cnt;
            end
            // go is self clearing, reads back as zero
            default: rdata = '0;
        endcase
    end

    assign apb_rsp = '{
        prdata:  rdata,
        pready:  1'b1,
        pslverr: access && (!addr_ok || go_err)
    };

    always_ff @(posedge clk) begin
        if (wr_access && (apb_req.paddr == REG_CMD)) begin
            cmd.offset <= apb_req.pwdata[1:0];
            cmd.bpw    <= apb_req.pwdata[3:2];
            cmd.words  <= apb_req.pwdata[16 +: WLEN_MAX];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_valid <= 1'b0;
            busy      <= 1'b0;
            done_cnt  <= '0;
        end else begin
            if (cmd_valid && cmd_ready) begin
                cmd_valid <= 1'b0;
            end
            if (cmd_done) begin
                busy     <= 1'b0;
                done_cnt <= done_cnt + 1'b1;
            end
            // rejected go leaves everything as it was
            if (go_wr && !busy) begin
                cmd_valid <= 1'b1;
                busy      <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/unpack_top.sv */
`timescale 1ns/1ps
`default_nettype none

module unpack_top #(
    parameter int WORDS_ZERO = 0,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  apb_pkg::apb_req_t        apb_req,
    output apb_pkg::apb_rsp_t        apb_rsp,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  unpack_pkg::pack_word_t   in_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output unpack_pkg::unpack_beat_t out_beat
);
    import unpack_pkg::*;

    unpack_cmd_t  cmd;
    logic         cmd_valid;
    logic         cmd_ready;
    logic         cmd_done;

    // input FIFO to unpacker
    pack_word_t   fifo_word;
    logic         fifo_valid;
    logic         fifo_ready;

    // unpacker to output FIFO
    unpack_beat_t beat;
    logic         beat_valid;
    logic         beat_ready;

    unpack_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_done  (cmd_done)
    );

    stream_fifo #(
        .T          (pack_word_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) in_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready),
        .out_data  (fifo_word)
    );

    data_unpacker #(
        .WORDS_ZERO (WORDS_ZERO)
    ) u_unpacker (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_done  (cmd_done),
        .in_valid  (fifo_valid),
        .in_ready  (fifo_ready),
        .in_word   (fifo_word),
        .out_valid (beat_valid),
        .out_ready (beat_ready),
        .out_beat  (beat)
    );

    stream_fifo #(
        .T          (unpack_beat_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) out_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (beat_valid),
        .in_ready  (beat_ready),
        .in_data   (beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_beat)
    );

endmodule

`default_nettype wire

/* verification/unpack_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module unpack_checker (
    input logic                     clk,
    input logic                     rst,
    input apb_pkg::apb_req_t        apb_req,
    input apb_pkg::apb_rsp_t        apb_rsp,
    input logic                     out_valid,
    input logic                     out_ready,
    input unpack_pkg::unpack_beat_t out_beat
);

    // a stalled beat is held until it is taken
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
        else $error("out_beat changed while out_valid was high and out_ready low");

    // no wait states on the register port
    ready_high: assert property (@(posedge clk) disable iff (rst) apb_rsp.pready)
        else $error("pready went low");

    slverr_access: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
        else $error("pslverr outside an APB access cycle");

endmodule

bind unpack_top unpack_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
);

`default_nettype wire

/* verification/unpack_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module unpack_tb;
    import apb_pkg::*;
    import unpack_pkg::*;

    localparam int WORDS_ZERO = 0;
    localparam int FIFO_DEPTH = 4;
    localparam int MAX_TESTS  = 32;

    logic         clk = 1'b0;
    logic         rst;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;
    logic         in_valid;
    logic         in_ready;
    pack_word_t   in_data;
    logic         out_valid;
    logic         out_ready;
    unpack_beat_t out_beat;

    // five columns per test, see the tests file
    logic [15:0]  tests_mem [5*MAX_TESTS];
    integer       seed;
    int           n_tests;
    int           limit;
    int           cycle_cnt;
    int           err_cnt;
    int           fail_cnt;
    bit           run_ended;

    unpack_top #(
        .WORDS_ZERO (WORDS_ZERO),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (limit > 0 && cycle_cnt > limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            run_ended = 1'b1;
            $display("FAIL: see errors above");
            $finish;
        end
    end

    final begin
        if (!run_ended) begin
            $display("run stopped before the tests finished");
            $display("FAIL: see errors above");
        end
    end

    // byte p of the packed stream, counting up from the first value
    function automatic logic [7:0] stream_byte(input int first, input int p);
        return 8'((first + p) % 256);
    endfunction

    // little-endian packing, byte 0 in bits 7:0
    function automatic logic [31:0] stream_word(input int first, input int w);
        logic [31:0] d;
        int          j;
        for (j = 0; j < 4; j++) begin
            d[8*j +: 8] = stream_byte(first, 4*w + j);
        end
        return d;
    endfunction

    function automatic logic [31:0] expected_data(input int first, input int offset,
                                                  input int bpw, input int k);
        logic [31:0] d;
        int          j;
        d = '0;
        for (j = 0; j <= bpw; j++) begin
            d[8*j +: 8] = stream_byte(first, offset + k*(bpw + 1) + j);
        end
        return d;
    endfunction

    function automatic logic ready_roll(input int stall_pct);
        return ($unsigned($random(seed)) % 100) >= stall_pct;
    endfunction

    // setup cycle, access cycle, response sampled in the middle of the access cycle
    task automatic apb_xfer(input logic wr, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        apb_req_t req;
        req        = '0;
        req.psel   = 1'b1;
        req.pwrite = wr;
        req.paddr  = addr;
        req.pwdata = wdata;
        @(posedge clk);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge clk);
        apb_req <= req;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic check_slverr(input logic got, input logic want, input string what);
        assert (got == want) else begin
            $display("ERR %0t: %s gave pslverr %0b, expected %0b", $time, what, got, want);
            err_cnt++;
        end
    endtask

    task automatic feed_words(input int first, input int nwords);
        int w;
        w = 0;
        while (w < nwords) begin
            if ($unsigned($random(seed)) % 4 == 0) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end else begin
                in_valid     <= 1'b1;
                in_data.data <= stream_word(first, w);
                @(posedge clk);
                while (!in_ready) begin
                    @(posedge clk);
                end
                w++;
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic take_beats(input int first, input int offset, input int bpw,
                              input int nbeats, input int stall_pct);
        int          k;
        logic [31:0] exp_data;
        k = 0;
        out_ready <= ready_roll(stall_pct);
        while (k < nbeats) begin
            @(posedge clk);
            if (out_valid && out_ready) begin
                exp_data = expected_data(first, offset, bpw, k);
                assert (out_beat.data == exp_data) else begin
                    $display("ERR %0t: beat %0d data %h, expected %h", $time, k,
                             out_beat.data, exp_data);
                    err_cnt++;
                end
                assert (out_beat.last == (k == nbeats - 1)) else begin
                    $display("ERR %0t: beat %0d last %0b, expected %0b", $time, k,
                             out_beat.last, (k == nbeats - 1));
                    err_cnt++;
                end
                k++;
            end
            out_ready <= ready_roll(stall_pct);
        end
        out_ready <= 1'b0;
    endtask

    initial begin
        int          t;
        int          offset, bpw, words, first, stall;
        int          nbeats, nwords, errs_before;
        logic [31:0] cmd_word;
        logic [31:0] rdata;
        logic        err;
        seed      = 32'h283b_e714;
        rst       = 1'b1;
        apb_req   = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        for (t = 0; t < 5*MAX_TESTS; t++) begin
            tests_mem[t] = '1;
        end
        $readmemh("verification/unpack_tests.txt", tests_mem);
        n_tests = 0;
        limit   = 50;
        while (n_tests < MAX_TESTS && tests_mem[5*n_tests] != 16'hffff) begin
            limit += (8*tests_mem[5*n_tests + 2] + 40) * 4;
            n_tests++;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        apb_xfer(1'b0, 4'hc, '0, rdata, err);
        check_slverr(err, 1'b1, "read of unknown address");
        $display("unknown address read: %s", err ? "ok" : "failed");

        for (t = 0; t < n_tests; t++) begin
            offset      = tests_mem[5*t];
            bpw         = tests_mem[5*t + 1];
            words       = tests_mem[5*t + 2];
            first       = tests_mem[5*t + 3];
            stall       = tests_mem[5*t + 4];
            nbeats      = words + ((WORDS_ZERO != 0) ? 1 : 0);
            // input words touched by the bytes of all beats
            nwords      = (offset + nbeats*(bpw + 1) + 3) / 4;
            errs_before = err_cnt;
            cmd_word        = '0;
            cmd_word[1:0]   = 2'(offset);
            cmd_word[3:2]   = 2'(bpw);
            cmd_word[27:16] = 12'(words);
            apb_xfer(1'b1, REG_CMD, cmd_word, rdata, err);
            check_slverr(err, 1'b0, "command write");
            apb_xfer(1'b0, REG_CMD, '0, rdata, err);
            check_slverr(err, 1'b0, "command read");
            assert (rdata == cmd_word) else begin
                $display("ERR %0t: command read %h, expected %h", $time, rdata, cmd_word);
                err_cnt++;
            end
            apb_xfer(1'b1, REG_CTRL, 32'h1, rdata, err);
            check_slverr(err, 1'b0, "go write");
            // no input yet, so the command is still running
            apb_xfer(1'b1, REG_CTRL, 32'h1, rdata, err);
            check_slverr(err, 1'b1, "go write while busy");
            fork
                feed_words(first, nwords);
                take_beats(first, offset, bpw, nbeats, stall);
            join
            rdata = 32'h1;
            while (rdata[0]) begin
                apb_xfer(1'b0, REG_STATUS, '0, rdata, err);
            end
            assert (rdata[31:16] == 16'(t + 1)) else begin
                $display("ERR %0t: done count %0d, expected %0d", $time, rdata[31:16], t + 1);
                err_cnt++;
            end
            assert (!out_valid) else begin
                $display("ERR %0t: extra beat after the last one of test %0d", $time, t);
                err_cnt++;
            end
            if (err_cnt == errs_before) begin
                $display("test %0d: offset %0d bpw %0d words %0d stall %0d%%: ok",
                         t, offset, bpw, words, stall);
            end else begin
                fail_cnt++;
                $display("test %0d: offset %0d bpw %0d words %0d stall %0d%%: %0d errors",
                         t, offset, bpw, words, stall, err_cnt - errs_before);
            end
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_tests, n_tests - fail_cnt, fail_cnt, err_cnt);
        run_ended = 1'b1;
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/unpack_tests.txt */
// columns, all hex: offset bpw words first_byte stall_pct
// bpw is bytes per word minus one, stall_pct is the chance that out_ready is low
0 0 08 00 00
0 1 07 10 00
0 2 09 20 00
0 3 06 30 00
1 0 0a 40 19
1 1 09 50 19
1 2 07 60 19
1 3 08 70 19
2 0 0b 80 32
2 1 08 90 32
2 2 0a a0 32
2 3 07 b0 32
3 0 09 c0 4b
3 1 0a d0 4b
3 2 08 e0 4b
3 3 0c f0 4b
3 3 01 fe 00
1 2 01 ff 32

/* tb.f */
verilog/unpack_pkg.sv
verilog/apb_pkg.sv
verilog/stream_fifo.sv
verilog/data_unpacker.sv
verilog/unpack_regs.sv
verilog/unpack_top.sv
verification/unpack_checker.sv
verification/unpack_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the unpacker testbench with Verilator, run it and check the log
verilator --binary --assert -Wno-fatal --top-module unpack_tb -f tb.f -o unpack_sim \
    && ./obj_dir/unpack_sim | tee sim.log \
    && grep -q "^PASS: all tests$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
